// File: Makefile
# Verilator build and run for the DZ receive path testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_dz_rx
FLIST     := dz_rx.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dz_line_pkg.sv
/*
 * Serial line constants for the DZ receive path
 * Line count, line-number width and character width
 * Shared by the scanner, the silo word layout and the top level
 */

package dz_line_pkg;

   ////////////////////
   // Line set
   ////////////////////

   // Eight lines per multiplexer
   localparam int NUM_LINES = 8;

   // Bits to number a line
   localparam int LINE_W = 3;

   ////////////////////
   // Character
   ////////////////////

   // Assembled character from a line, parity bit already stripped
   localparam int CHAR_W = 8;

   // NUM_LINES must fit in LINE_W.
   // A wider multiplexer would need both changed together,
   // and the silo entry grows with LINE_W

endpackage

// File: dz_rbuf_pkg.sv
/*
 * Receive buffer word layout
 * Field positions of one silo entry
 * Width of the host word with the data-valid bit on top
 */

package dz_rbuf_pkg;

   ////////////////////
   // Silo entry fields
   ////////////////////

   // Character in the low bits
   localparam int CHAR_LSB = 0;

   // Line number sits right above the character
   localparam int LINE_LSB = CHAR_LSB + dz_line_pkg::CHAR_W;

   // Error flags above the line number
   localparam int PE_BIT = LINE_LSB + dz_line_pkg::LINE_W;
   localparam int FE_BIT = PE_BIT + 1;

   // Overrun, set by the scanner or by a full silo
   localparam int OVRN_BIT = FE_BIT + 1;

   // One silo entry, 14 bits with the default line set
   localparam int ENTRY_W = OVRN_BIT + 1;

   ////////////////////
   // Host word
   ////////////////////

   // Data valid on top of the entry
   localparam int DVAL_BIT = ENTRY_W;
   localparam int RBUF_W = ENTRY_W + 1;

endpackage

// File: dz_rx.f
dz_line_pkg.sv
dz_rbuf_pkg.sv
dz_rx_scan.sv
dz_silo.sv
dz_rx_alarm.sv
dz_rx.sv
tb_dz_rx.sv

// File: dz_rx.sv
/*
 * DZ receive path top level
 * Scanner, silo and alarm block tied to the host ports
 */

`timescale 1ns/100ps

module dz_rx #(
   parameter int SILO_DEPTH  = 64,
   parameter int ALARM_LEVEL = 16
) (
   input  logic                                                   clk,
   input  logic                                                   rst,
   input  logic                                                   clr,
   input  logic                                                   rie,
   input  logic                                                   sae,
   input  logic                                                   rbuf_rd,
   input  logic [dz_line_pkg::NUM_LINES-1:0]                      rx_stb,
   input  logic [dz_line_pkg::NUM_LINES-1:0][dz_line_pkg::CHAR_W-1:0] rx_char,
   input  logic [dz_line_pkg::NUM_LINES-1:0]                      rx_fe,
   input  logic [dz_line_pkg::NUM_LINES-1:0]                      rx_pe,
   output logic [dz_rbuf_pkg::RBUF_W-1:0]                         rbuf,
   output logic                                                   rx_irq
);

   import dz_rbuf_pkg::*;

   logic               silo_wr;
   logic [ENTRY_W-1:0] silo_din;
   logic               silo_rd;
   logic [ENTRY_W-1:0] silo_dout;
   logic               silo_dval;
   logic               silo_empty;

   // Lines into the silo
   dz_rx_scan i_scan (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .rx_stb   (rx_stb),
      .rx_char  (rx_char),
      .rx_fe    (rx_fe),
      .rx_pe    (rx_pe),
      .silo_wr  (silo_wr),
      .silo_din (silo_din)
   );

   // Host pop goes straight to the silo
   assign silo_rd = rbuf_rd;

   dz_silo #(
      .SILO_DEPTH (SILO_DEPTH)
   ) i_silo (
      .clk   (clk),
      .rst   (rst),
      .clr   (clr),
      .wr    (silo_wr),
      .din   (silo_din),
      .rd    (silo_rd),
      .dout  (silo_dout),
      .dval  (silo_dval),
      .empty (silo_empty)
   );

   dz_rx_alarm #(
      .ALARM_LEVEL (ALARM_LEVEL)
   ) i_alarm (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .silo_wr (silo_wr),
      .silo_rd (silo_rd),
      .empty   (silo_empty),
      .rie     (rie),
      .sae     (sae),
      .rx_irq  (rx_irq)
   );

   // Valid flag above the head entry
   assign rbuf[DVAL_BIT]      = silo_dval;
   assign rbuf[ENTRY_W-1:0]   = silo_dout;

endmodule

// File: dz_rx_alarm.sv
/*
 * Silo alarm counter and receive interrupt
 * Counts stores since the last host read, saturating at the alarm level
 */

`timescale 1ns/100ps

module dz_rx_alarm #(
   parameter int ALARM_LEVEL = 16
) (
   input  logic clk,
   input  logic rst,
   input  logic clr,
   input  logic silo_wr,
   input  logic silo_rd,
   input  logic empty,
   input  logic rie,
   input  logic sae,
   output logic rx_irq
);

   localparam int CNT_W = $clog2(ALARM_LEVEL + 1);

   ////////////////////
   // Alarm counter
   ////////////////////

   logic [CNT_W-1:0] alarm_cnt;
   logic             alarm_hit;
   logic             irq_cond;

   assign alarm_hit = (alarm_cnt == CNT_W'(ALARM_LEVEL));

   // A read restarts the count, a store in the same cycle is not counted
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         alarm_cnt <= '0;
      else if (clr || silo_rd)
         alarm_cnt <= '0;
      else if (silo_wr && !alarm_hit)
         alarm_cnt <= alarm_cnt + CNT_W'(1);
   end

   ////////////////////
   // Interrupt
   ////////////////////

   // Alarm mode waits for the level, otherwise any data
   assign irq_cond = rie && (sae ? alarm_hit : !empty);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rx_irq <= 1'b0;
      else if (clr)
         rx_irq <= 1'b0;
      else
         rx_irq <= irq_cond;
   end

endmodule

// File: dz_rx_scan.sv
/*
 * Receive scanner
 * One holding register per line, loaded by the line strobe
 * Fixed priority pick of the lowest pending line into the silo
 */

`timescale 1ns/100ps

module dz_rx_scan (
   input  logic                                                   clk,
   input  logic                                                   rst,
   input  logic                                                   clr,
   input  logic [dz_line_pkg::NUM_LINES-1:0]                      rx_stb,
   input  logic [dz_line_pkg::NUM_LINES-1:0][dz_line_pkg::CHAR_W-1:0] rx_char,
   input  logic [dz_line_pkg::NUM_LINES-1:0]                      rx_fe,
   input  logic [dz_line_pkg::NUM_LINES-1:0]                      rx_pe,
   output logic                                                   silo_wr,
   output logic [dz_rbuf_pkg::ENTRY_W-1:0]                        silo_din
);

   import dz_line_pkg::*;
   import dz_rbuf_pkg::*;

   ////////////////////
   // Holding registers
   ////////////////////

   // Character and flags as last delivered by each line
   logic [CHAR_W-1:0]    hold_char [NUM_LINES];
   logic [NUM_LINES-1:0] hold_fe;
   logic [NUM_LINES-1:0] hold_pe;

   // Waiting for the scanner
   logic [NUM_LINES-1:0] pend;
   // Earlier character was lost on this line
   logic [NUM_LINES-1:0] hold_ovr;

   // Lowest pending line
   logic [LINE_W-1:0]    sel_line;

   // Payload follows the strobe only
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
         if (rx_stb[i])
         begin
            hold_char[i] <= rx_char[i];
            hold_fe[i]   <= rx_fe[i];
            hold_pe[i]   <= rx_pe[i];
         end
      end
   end

   // Pending and overrun bookkeeping
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pend     <= '0;
         hold_ovr <= '0;
      end
      else if (clr)
      begin
         pend     <= '0;
         hold_ovr <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_LINES; i++)
         begin
            if (rx_stb[i])
            begin
               pend[i] <= 1'b1;
               // Lost only if the old one is not leaving this cycle
               hold_ovr[i] <= pend[i] && !(silo_wr && sel_line == LINE_W'(i));
            end
            else if (silo_wr && sel_line == LINE_W'(i))
               pend[i] <= 1'b0;
         end
      end
   end

   ////////////////////
   // Scanner
   ////////////////////

   // Walk down so line 0 wins
   always_comb
   begin
      sel_line = '0;
      for (int i = NUM_LINES - 1; i >= 0; i--)
      begin
         if (pend[i])
            sel_line = LINE_W'(i);
      end
   end

   // Any pending line goes to the silo at the next edge
   assign silo_wr = |pend;

   // Entry for the selected line
   always_comb
   begin
      silo_din                      = '0;
      silo_din[CHAR_LSB +: CHAR_W]  = hold_char[sel_line];
      silo_din[LINE_LSB +: LINE_W]  = sel_line;
      silo_din[PE_BIT]              = hold_pe[sel_line];
      silo_din[FE_BIT]              = hold_fe[sel_line];
      silo_din[OVRN_BIT]            = hold_ovr[sel_line];
   end

   // Write comes from a pending line with no lower line left waiting
   a_scan_pick : assert property (@(posedge clk) disable iff (rst)
      silo_wr |-> pend[sel_line] &&
         ((pend & ((NUM_LINES'(1) << sel_line) - NUM_LINES'(1))) == '0));

endmodule

// File: dz_silo.sv
/*
 * Receive silo
 * Depth counter to the full count, wrapping read and write pointers
 * Newest entry replaced with overrun when full
 * Registered head word and valid flag
 */

`timescale 1ns/100ps

module dz_silo #(
   parameter int SILO_DEPTH = 64
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            clr,
   input  logic                            wr,
   input  logic [dz_rbuf_pkg::ENTRY_W-1:0] din,
   input  logic                            rd,
   output logic [dz_rbuf_pkg::ENTRY_W-1:0] dout,
   output logic                            dval,
   output logic                            empty
);

   import dz_rbuf_pkg::*;

   // Depth must hold SILO_DEPTH itself, not just SILO_DEPTH-1
   localparam int DEPTH_W = $clog2(SILO_DEPTH + 1);
   localparam int PTR_W   = (SILO_DEPTH > 1) ? $clog2(SILO_DEPTH) : 1;

   ////////////////////
   // Silo state
   ////////////////////

   logic [DEPTH_W-1:0] depth;
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   last_ptr;
   logic               full;
   logic               replace;
   logic               push;

   logic [ENTRY_W-1:0] mem [SILO_DEPTH];

   assign empty = (depth == '0);
   assign full  = (depth == DEPTH_W'(SILO_DEPTH));

   // Full with no pop this cycle, so overwrite the newest entry
   assign replace = wr && full && !rd;
   assign push    = wr && !replace;

   // Slot of the newest entry
   assign last_ptr = (wr_ptr == '0) ? PTR_W'(SILO_DEPTH - 1) : wr_ptr - PTR_W'(1);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         depth  <= '0;
         rd_ptr <= '0;
         wr_ptr <= '0;
      end
      else if (clr)
      begin
         depth  <= '0;
         rd_ptr <= '0;
         wr_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(SILO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         if (rd)
            rd_ptr <= (rd_ptr == PTR_W'(SILO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         // Push and pop together leave the depth alone
         if (push && !rd)
            depth <= depth + DEPTH_W'(1);
         else if (rd && !push)
            depth <= depth - DEPTH_W'(1);
      end
   end

   ////////////////////
   // Storage
   ////////////////////

   // Replacement keeps the line overrun and adds the silo overrun
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= din;
      else if (replace)
      begin
         mem[last_ptr]           <= din;
         mem[last_ptr][OVRN_BIT] <= 1'b1;
      end
   end

   ////////////////////
   // Head output
   ////////////////////

   // Head word trails the pointer by one cycle
   always_ff @(posedge clk)
   begin
      dout <= mem[rd_ptr];
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dval <= 1'b0;
      else if (clr)
         dval <= 1'b0;
      else
         dval <= !empty;
   end

   // Count never passes the silo size
   a_depth_bound : assert property (@(posedge clk) disable iff (rst)
      depth <= DEPTH_W'(SILO_DEPTH));

   // Host pops only what is there
   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst)
      rd |-> !empty);

endmodule

// File: tb_dz_rx.sv
/*
 * Testbench for the DZ receive path
 * Line and host stimulus, queue model of scanner and silo
 * Per-cycle compare of rbuf and rx_irq, timeout and summary
 */

`timescale 1ns/100ps

module tb_dz_rx;

   import dz_line_pkg::*;
   import dz_rbuf_pkg::*;

   localparam int DEPTH      = 64;
   localparam int ALARM      = 16;
   localparam int MAX_CYCLES = 4000;

   logic                             clk;
   logic                             rst;
   logic                             clr;
   logic                             rie;
   logic                             sae;
   logic                             rbuf_rd;
   logic [NUM_LINES-1:0]             rx_stb;
   logic [NUM_LINES-1:0][CHAR_W-1:0] rx_char;
   logic [NUM_LINES-1:0]             rx_fe;
   logic [NUM_LINES-1:0]             rx_pe;
   logic [RBUF_W-1:0]                rbuf;
   logic                             rx_irq;

   // Silo contents as the host should see them, head first
   logic [ENTRY_W-1:0]   exp_q[$];
   // Words taken by the last drain
   logic [ENTRY_W-1:0]   got_q[$];
   logic [CHAR_W-1:0]    m_char [NUM_LINES];
   logic [NUM_LINES-1:0] m_fe;
   logic [NUM_LINES-1:0] m_pe;
   logic [NUM_LINES-1:0] m_pend;
   logic [NUM_LINES-1:0] m_ovr;
   int                   m_cnt;
   logic                 exp_dval = 1'b0;
   logic [ENTRY_W-1:0]   exp_head;
   logic                 exp_irq = 1'b0;
   int                   errors = 0;
   int                   checks = 0;
   int                   cycles = 0;

   dz_rx i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Entry layout: overrun, framing, parity, line, character
   function automatic logic [ENTRY_W-1:0] ref_entry(input logic [LINE_W-1:0] line,
      input logic [CHAR_W-1:0] ch, input logic fe, input logic pe, input logic ovr);
      return {ovr, fe, pe, line, ch};
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   always @(posedge clk)
   begin
      int   sel;
      logic wr;
      if (rst || clr)
      begin
         m_pend   = '0;
         m_ovr    = '0;
         m_cnt    = 0;
         exp_q.delete();
         exp_dval = 1'b0;
         exp_irq  = 1'b0;
      end
      else
      begin
         // First pending line from the bottom
         wr  = 1'b0;
         sel = 0;
         for (int i = 0; i < NUM_LINES; i++)
         begin
            if (m_pend[i] && !wr)
            begin
               sel = i;
               wr  = 1'b1;
            end
         end
         // Registered outputs see the state before this edge
         exp_dval = (exp_q.size() != 0);
         if (exp_dval)
            exp_head = exp_q[0];
         exp_irq = rie && (sae ? (m_cnt == ALARM) : exp_dval);
         if (rbuf_rd)
         begin
            m_cnt = 0;
            if (exp_dval)
               void'(exp_q.pop_front());
            else
            begin
               errors++;
               $display("Host pop issued while the silo model is empty");
            end
         end
         else if (wr && m_cnt < ALARM)
            m_cnt++;
         // Full silo keeps its size, newest entry rewritten with overrun
         if (wr && exp_q.size() == DEPTH)
            exp_q[DEPTH-1] = ref_entry(LINE_W'(sel), m_char[sel], m_fe[sel], m_pe[sel], 1'b1);
         else if (wr)
            exp_q.push_back(ref_entry(LINE_W'(sel), m_char[sel], m_fe[sel], m_pe[sel],
                                      m_ovr[sel]));
         for (int i = 0; i < NUM_LINES; i++)
         begin
            if (rx_stb[i])
            begin
               // Held and not leaving now, so the old character is lost
               m_ovr[i]  = m_pend[i] && !(wr && sel == i);
               m_pend[i] = 1'b1;
               m_char[i] = rx_char[i];
               m_fe[i]   = rx_fe[i];
               m_pe[i]   = rx_pe[i];
            end
            else if (wr && sel == i)
               m_pend[i] = 1'b0;
         end
      end
   end

   ////////////////////
   // Compare and timeout
   ////////////////////

   // Mid-cycle, registered outputs are settled
   always @(negedge clk)
   begin
      if (!rst)
      begin
         checks++;
         if (rbuf[DVAL_BIT] !== exp_dval)
         begin
            errors++;
            $display("FAILED rbuf_dval exp 0x%0h got 0x%0h", exp_dval, rbuf[DVAL_BIT]);
         end
         else if (exp_dval && rbuf[ENTRY_W-1:0] !== exp_head)
         begin
            errors++;
            $display("FAILED rbuf exp 0x%0h got 0x%0h", exp_head, rbuf[ENTRY_W-1:0]);
         end
         if (rx_irq !== exp_irq)
         begin
            errors++;
            $display("FAILED rx_irq exp 0x%0h got 0x%0h", exp_irq, rx_irq);
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout, stimulus still running after %0d cycles", cycles);
         $display("Checks %0d, errors %0d", checks, errors);
         $display("TB FAILED");
         $finish;
      end
   end

   ////////////////////
   // Stimulus tasks
   ////////////////////

   // Strobe the masked lines with random payload for one cycle
   task automatic drive_cycle(input logic [NUM_LINES-1:0] mask);
      logic [31:0] r;
      @(negedge clk);
      rbuf_rd = 1'b0;
      rx_stb  = mask;
      for (int i = 0; i < NUM_LINES; i++)
      begin
         r          = $urandom;
         rx_char[i] = r[7:0];
         rx_fe[i]   = r[8];
         rx_pe[i]   = r[9];
      end
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         rx_stb  = '0;
         rbuf_rd = 1'b0;
      end
   endtask

   // One pop if data is valid; the idle cycle after keeps pops two apart
   task automatic pop_one(output bit popped);
      @(negedge clk);
      rx_stb  = '0;
      rbuf_rd = 1'b0;
      popped  = rbuf[DVAL_BIT];
      if (popped)
      begin
         got_q.push_back(rbuf[ENTRY_W-1:0]);
         rbuf_rd = 1'b1;
         @(negedge clk);
         rbuf_rd = 1'b0;
      end
   endtask

   task automatic drain(input int want_n);
      bit popped;
      int n;
      n      = 0;
      popped = 1'b1;
      got_q.delete();
      while (popped)
      begin
         pop_one(popped);
         if (popped)
            n++;
      end
      if (n != want_n)
      begin
         errors++;
         $display("Silo drain returned %0d words where %0d were expected", n, want_n);
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      logic [31:0]          r;
      logic [NUM_LINES-1:0] mask;
      logic [LINE_W-1:0]    sent[$];
      logic [ENTRY_W-1:0]   want;
      void'($urandom(32'he206bb72));
      rst     = 1'b1;
      clr     = 1'b0;
      rie     = 1'b0;
      sae     = 1'b0;
      rbuf_rd = 1'b0;
      rx_stb  = '0;
      rx_char = '0;
      rx_fe   = '0;
      rx_pe   = '0;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      // Single characters on random lines, data interrupt held off then on
      for (int k = 0; k < 12; k++)
      begin
         r    = $urandom;
         mask = '0;
         mask[r[2:0]] = 1'b1;
         sent.push_back(r[2:0]);
         drive_cycle(mask);
         idle(1);
         if (k == 6)
            rie = 1'b1;
      end
      idle(4);
      drain(12);
      for (int k = 0; k < got_q.size() && k < sent.size(); k++)
      begin
         if (got_q[k][LINE_LSB +: LINE_W] !== sent[k])
         begin
            errors++;
            $display("FAILED rbuf line exp 0x%0h got 0x%0h", sent[k],
                     got_q[k][LINE_LSB +: LINE_W]);
         end
      end

      // Same-cycle strobes come out in ascending line order
      for (int k = 0; k < 4; k++)
      begin
         r    = $urandom;
         mask = r[NUM_LINES-1:0];
         mask[r[10:8]] = 1'b1;
         drive_cycle(mask);
         idle(10);
         drain($countones(mask));
         for (int j = 1; j < got_q.size(); j++)
         begin
            if (got_q[j][LINE_LSB +: LINE_W] <= got_q[j-1][LINE_LSB +: LINE_W])
            begin
               errors++;
               $display("FAILED rbuf line exp above 0x%0h got 0x%0h",
                        got_q[j-1][LINE_LSB +: LINE_W], got_q[j][LINE_LSB +: LINE_W]);
            end
         end
      end

      // Line 7 restruck while lines 0 to 6 are still waiting
      drive_cycle('1);
      drive_cycle(NUM_LINES'(8'h80));
      want = ref_entry(3'd7, rx_char[7], rx_fe[7], rx_pe[7], 1'b1);
      idle(10);
      drain(8);
      if (got_q[7] !== want)
      begin
         errors++;
         $display("FAILED rbuf line 7 entry exp 0x%0h got 0x%0h", want, got_q[7]);
      end

      // 65 stores into 64 entries, the last one replaces the newest
      rie = 1'b0;
      for (int k = 0; k < DEPTH + 1; k++)
      begin
         drive_cycle(NUM_LINES'(8'h01));
         want = ref_entry(3'd0, rx_char[0], rx_fe[0], rx_pe[0], 1'b1);
      end
      idle(4);
      drain(DEPTH);
      for (int k = 0; k < DEPTH - 1; k++)
      begin
         if (got_q[k][OVRN_BIT] !== 1'b0)
         begin
            errors++;
            $display("FAILED rbuf overrun at word %0d exp 0x0 got 0x%0h", k, got_q[k][OVRN_BIT]);
         end
      end
      if (got_q[DEPTH-1] !== want)
      begin
         errors++;
         $display("FAILED rbuf last entry exp 0x%0h got 0x%0h", want, got_q[DEPTH-1]);
      end

      // Alarm mode, rises at 16 stores, falls on a read, masked by rie
      sae = 1'b1;
      rie = 1'b1;
      for (int k = 0; k < 20; k++)
         drive_cycle(NUM_LINES'(1) << (k % NUM_LINES));
      idle(3);
      if (rx_irq !== 1'b1)
      begin
         errors++;
         $display("FAILED rx_irq after alarm level exp 0x1 got 0x%0h", rx_irq);
      end
      drain(20);
      rie = 1'b0;
      for (int k = 0; k < 20; k++)
         drive_cycle(NUM_LINES'(1) << (k % NUM_LINES));
      idle(4);
      rie = 1'b1;
      idle(3);
      drain(20);
      sae = 1'b0;

      // Master clear with data held and the interrupt up
      drive_cycle(NUM_LINES'(8'h0f));
      idle(6);
      @(negedge clk);
      clr = 1'b1;
      @(negedge clk);
      clr = 1'b0;
      if ({rbuf[DVAL_BIT], rx_irq} !== 2'b00)
      begin
         errors++;
         $display("FAILED rbuf_dval,rx_irq after clr exp 0x0 got 0x%0h", {rbuf[DVAL_BIT], rx_irq});
      end
      idle(4);
      drain(0);
      idle(4);

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule
